//--- hw/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

    //////////////////////////////
    // Word geometry
    //////////////////////////////

    // Byte lanes per 32-bit word
    localparam int LANES = 4;

    //////////////////////////////
    // Access size
    //////////////////////////////

    // Bytes accessed is the code plus one
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_TRIPLE = 2'd2,
        SIZE_WORD   = 2'd3
    } mem_size_e;

    //////////////////////////////
    // Data word
    //////////////////////////////

    // Whole word for ports and extension, byte view for lane rotation
    typedef union packed {
        logic [31:0]               word;
        logic [LANES-1:0][7:0]     lanes;
    } mem_word_u;

endpackage

`default_nettype wire

//--- hw/lane_steer.sv
`timescale 1ns/1ps
`default_nettype none

module lane_steer #(
    parameter int ADDR_W = 10
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire  [ADDR_W-1:0]                     addr,
    input  wire  dmem_pkg::mem_size_e             size,
    input  wire                                   wr_en,
    input  wire  dmem_pkg::mem_word_u             wr_data,
    output logic [dmem_pkg::LANES-1:0][ADDR_W-3:0] lane_row,
    output logic [dmem_pkg::LANES-1:0]            lane_we,
    output logic [dmem_pkg::LANES-1:0][7:0]       lane_wdata
);

    localparam int ROW_W = ADDR_W - 2;

    logic [1:0]                          offset;
    logic [ROW_W-1:0]                    base_row;
    logic [ROW_W-1:0]                    next_row;
    logic [dmem_pkg::LANES-1:0][1:0]     byte_idx;
    logic [ADDR_W:0]                     last_byte;

    //////////////////////////////
    // Address split
    //////////////////////////////

    assign offset   = addr[1:0];
    assign base_row = addr[ADDR_W-1:2];

    // Row for lanes below the offset, which the access wraps into
    assign next_row = base_row + ROW_W'(1);

    // Address of the last byte touched, with one carry bit
    assign last_byte = {1'b0, addr} + {{(ADDR_W-1){1'b0}}, size};

    //////////////////////////////
    // Per-lane steering
    //////////////////////////////

    always_comb
    begin
        for (int j = 0; j < dmem_pkg::LANES; j++)
        begin
            // Which byte of the value lands in this lane
            byte_idx[j] = 2'(j) - offset;

            // Lanes left of the start offset belong to the following row
            if (2'(j) < offset)
            begin
                lane_row[j] = next_row;
            end
            else
            begin
                lane_row[j] = base_row;
            end

            // Only bytes inside the access size are written
            lane_we[j]    = wr_en && (byte_idx[j] <= size);
            lane_wdata[j] = wr_data.lanes[byte_idx[j]];
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // A store must stay inside the memory, no wrap to address zero
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !last_byte[ADDR_W])
    else
        $error("lane_steer: store at %h size %0d runs past end of memory", addr, size);

endmodule

`default_nettype wire

//--- hw/byte_lane_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram #(
    parameter int ADDR_W = 10
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [ADDR_W-3:0] row,
    input  wire               we,
    input  wire  [7:0]        wdata,
    output logic [7:0]        rdata
);

    localparam int ROW_W = ADDR_W - 2;
    localparam int DEPTH = 2 ** ROW_W;

    //////////////////////////////
    // Storage
    //////////////////////////////

    logic [7:0] mem [0:DEPTH-1];

    // Write port
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[row] <= wdata;
        end
    end

    // Registered read, old data when the same row is written
    always_ff @(posedge clk)
    begin
        rdata <= mem[row];
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Unknown row or strobe would corrupt the array silently
    assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({row, we}))
    else
        $error("byte_lane_ram: unknown row or write enable");

    // Data written must be known too
    assert property (@(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(wdata))
    else
        $error("byte_lane_ram: unknown write data at row %h", row);

endmodule

`default_nettype wire

//--- hw/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align #(
    parameter int ADDR_W = 10
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             rd_en,
    input  wire  [ADDR_W-1:0]               addr,
    input  wire  dmem_pkg::mem_size_e       size,
    input  wire                             sign,
    input  wire  [dmem_pkg::LANES-1:0][7:0] lane_rdata,
    output dmem_pkg::mem_word_u             rd_data,
    output logic                            rd_valid
);

    logic [1:0]               offset_q;
    dmem_pkg::mem_size_e      size_q;
    logic                     sign_q;
    dmem_pkg::mem_word_u      rot;
    logic                     fill_bit;

    //////////////////////////////
    // Request register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_en;
        end
    end

    // Captured with the lane read so they line up with lane_rdata
    always_ff @(posedge clk)
    begin
        offset_q <= addr[1:0];
        size_q   <= size;
        sign_q   <= sign;
    end

    //////////////////////////////
    // Rotate and extend
    //////////////////////////////

    // Byte at the access address becomes byte 0
    always_comb
    begin
        for (int k = 0; k < dmem_pkg::LANES; k++)
        begin
            rot.lanes[k] = lane_rdata[2'(k) + offset_q];
        end
    end

    // Top bit of the highest accessed byte, bit 7, 15, 23 or 31
    assign fill_bit = sign_q & rot.word[{size_q, 3'b111}];

    always_comb
    begin
        for (int k = 0; k < dmem_pkg::LANES; k++)
        begin
            if (2'(k) <= size_q)
            begin
                rd_data.lanes[k] = rot.lanes[k];
            end
            else
            begin
                rd_data.lanes[k] = {8{fill_bit}};
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Unsigned narrow loads leave nothing above the accessed bytes
    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_valid && !sign_q && size_q != dmem_pkg::SIZE_WORD)
            |-> ((rd_data.word >> (8 * (int'(size_q) + 1))) == 32'h0))
    else
        $error("load_align: unsigned load %h has nonzero upper bytes", rd_data.word);

endmodule

`default_nettype wire

//--- hw/dmem_top.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_top #(
    parameter int ADDR_W = 10
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [ADDR_W-1:0]          addr,
    input  wire  dmem_pkg::mem_size_e  size,
    input  wire                        sign,
    input  wire                        wr_en,
    input  wire  dmem_pkg::mem_word_u  wr_data,
    input  wire                        rd_en,
    output dmem_pkg::mem_word_u        rd_data,
    output logic                       rd_valid
);

    localparam int ROW_W = ADDR_W - 2;

    logic [dmem_pkg::LANES-1:0][ROW_W-1:0] lane_row;
    logic [dmem_pkg::LANES-1:0]            lane_we;
    logic [dmem_pkg::LANES-1:0][7:0]       lane_wdata;
    logic [dmem_pkg::LANES-1:0][7:0]       lane_rdata;

    //////////////////////////////
    // Address steering
    //////////////////////////////

    lane_steer #(
        .ADDR_W     (ADDR_W)
    ) u_steer (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .size       (size),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .lane_row   (lane_row),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata)
    );

    //////////////////////////////
    // Byte lanes
    //////////////////////////////

    for (genvar j = 0; j < dmem_pkg::LANES; j++)
    begin : g_lane
        byte_lane_ram #(
            .ADDR_W (ADDR_W)
        ) u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .row    (lane_row[j]),
            .we     (lane_we[j]),
            .wdata  (lane_wdata[j]),
            .rdata  (lane_rdata[j])
        );
    end

    //////////////////////////////
    // Load formatting
    //////////////////////////////

    load_align #(
        .ADDR_W     (ADDR_W)
    ) u_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (rd_en),
        .addr       (addr),
        .size       (size),
        .sign       (sign),
        .lane_rdata (lane_rdata),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

endmodule

`default_nettype wire

//--- test/dmem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_tb;

    localparam int ADDR_W        = 10;
    localparam int MEM_BYTES     = 2 ** ADDR_W;
    localparam int ROWS          = MEM_BYTES / 4;
    localparam int VALID_TIMEOUT = 8;

    logic                clk;
    logic                rst_n;
    logic [ADDR_W-1:0]   addr;
    dmem_pkg::mem_size_e size;
    logic                sign;
    logic                wr_en;
    dmem_pkg::mem_word_u wr_data;
    logic                rd_en;
    dmem_pkg::mem_word_u rd_data;
    logic                rd_valid;

    // Byte-wide reference copy of the memory
    logic [7:0]  model_mem [0:MEM_BYTES-1];

    // Expected response for the read sampled at the last edge
    logic        exp_valid;
    logic [31:0] exp_data;

    int valid_errors   = 0;
    int data_errors    = 0;
    int timeout_errors = 0;
    int reads_checked  = 0;

    //////////////////////////////
    // Clock and DUT
    //////////////////////////////

    initial clk = 1'b0;

    always #50 clk = ~clk;

    dmem_top #(
        .ADDR_W   (ADDR_W)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .size     (size),
        .sign     (sign),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Byte k of an n-byte access lives at address a+k
    function automatic logic [31:0] model_load(input logic [ADDR_W-1:0] a,
                                               input logic [1:0] sz, input logic sg);
        int                n;
        logic [ADDR_W-1:0] ba;
        logic [31:0]       v;
        n  = int'(sz) + 1;
        v  = '0;
        ba = a;
        for (int k = 0; k < n; k++)
        begin
            ba = a + ADDR_W'(k);
            v  = v | (32'(model_mem[ba]) << (8 * k));
        end
        // Fill above the access from bit 7 of the highest byte
        if (sg && model_mem[ba][7])
        begin
            v = v | (32'hFFFF_FFFF << (8 * n));
        end
        return v;
    endfunction

    task automatic model_store(input logic [ADDR_W-1:0] a, input logic [1:0] sz,
                               input logic [31:0] d);
        logic [ADDR_W-1:0] ba;
        for (int k = 0; k <= int'(sz); k++)
        begin
            ba = a + ADDR_W'(k);
            model_mem[ba] = 8'(d >> (8 * k));
        end
    endtask

    // Read sees the old bytes before the write lands
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            exp_valid <= 1'b0;
            exp_data  <= '0;
        end
        else
        begin
            if (exp_valid)
            begin
                reads_checked = reads_checked + 1;
            end
            exp_valid <= rd_en;
            if (rd_en)
            begin
                exp_data <= model_load(addr, size, sign);
            end
            if (wr_en)
            begin
                model_store(addr, size, wr_data.word);
            end
        end
    end

    //////////////////////////////
    // Response checks
    //////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n) rd_valid == exp_valid)
    else
    begin
        valid_errors = valid_errors + 1;
        $display("MISMATCH rd_valid: got %h expected %h at %0t",
                 $sampled(rd_valid), $sampled(exp_valid), $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid |-> (rd_data.word == exp_data))
    else
    begin
        data_errors = data_errors + 1;
        $display("MISMATCH rd_data: got %h expected %h at %0t",
                 $sampled(rd_data.word), $sampled(exp_data), $time);
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Pattern that changes with every address bit
    function automatic logic [31:0] fill_word(input logic [ADDR_W-1:0] a);
        return (32'(a) * 32'h0100_0193) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr(input int n);
        return ADDR_W'($urandom_range(MEM_BYTES - n));
    endfunction

    task automatic drive_cycle(input logic we, input logic re, input logic [ADDR_W-1:0] a,
                               input logic [1:0] sz, input logic sg, input logic [31:0] d);
        @(posedge clk);
        wr_en        <= we;
        rd_en        <= re;
        addr         <= a;
        size         <= dmem_pkg::mem_size_e'(sz);
        sign         <= sg;
        wr_data.word <= d;
    endtask

    task automatic go_idle();
        drive_cycle(1'b0, 1'b0, '0, 2'd0, 1'b0, '0);
    endtask

    task automatic wait_for_valid();
        int cycles = 0;
        bit seen   = 1'b0;
        while (!seen && cycles < VALID_TIMEOUT)
        begin
            @(negedge clk);
            seen   = (rd_valid === 1'b1);
            cycles = cycles + 1;
        end
        if (!seen)
        begin
            timeout_errors = timeout_errors + 1;
            $display("Timeout: rd_valid did not rise within %0d cycles of a read",
                     VALID_TIMEOUT);
        end
    endtask

    task automatic store(input logic [ADDR_W-1:0] a, input logic [1:0] sz,
                         input logic [31:0] d);
        drive_cycle(1'b1, 1'b0, a, sz, 1'b0, d);
    endtask

    task automatic load(input logic [ADDR_W-1:0] a, input logic [1:0] sz, input logic sg);
        drive_cycle(1'b0, 1'b1, a, sz, sg, '0);
        go_idle();
        wait_for_valid();
    endtask

    // Whole words of the row and both neighbours
    task automatic read_neighbor_words(input int row);
        for (int r = row - 1; r <= row + 1; r++)
        begin
            load(ADDR_W'(r * 4), 2'd3, 1'b0);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        logic [ADDR_W-1:0] a;
        logic [31:0]       d;
        logic [31:0]       top_mask;
        int                row;
        int                sz;

        void'($urandom(9472));
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        addr         = '0;
        size         = dmem_pkg::SIZE_BYTE;
        sign         = 1'b0;
        wr_data.word = '0;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Known contents everywhere before any load
        for (int w = 0; w < MEM_BYTES; w += 4)
        begin
            store(ADDR_W'(w), 2'd3, fill_word(ADDR_W'(w)));
        end

        // Aligned word round trip with sign clear and set
        for (int i = 0; i < 16; i++)
        begin
            a = ADDR_W'($urandom_range(ROWS - 1) * 4);
            d = $urandom();
            store(a, 2'd3, d);
            load(a, 2'd3, 1'b0);
            load(a, 2'd3, 1'b1);
        end

        // Back-to-back reads then a gap
        for (int i = 0; i < 8; i++)
        begin
            drive_cycle(1'b0, 1'b1, ADDR_W'(i * 4), 2'd3, 1'(i), '0);
        end
        go_idle();
        wait_for_valid();

        // Partial stores leave surrounding bytes alone
        for (int s = 0; s < 3; s++)
        begin
            for (int i = 0; i < 6; i++)
            begin
                row = int'($urandom_range(ROWS - 3, 1));
                a   = ADDR_W'(row * 4 + int'($urandom_range(3)));
                store(a, 2'(s), $urandom());
                read_neighbor_words(row);
            end
        end

        // Every size at every offset including row crossings
        for (int off = 0; off < 4; off++)
        begin
            for (int s = 0; s < 4; s++)
            begin
                for (int i = 0; i < 3; i++)
                begin
                    row = int'($urandom_range(ROWS - 3, 1));
                    a   = ADDR_W'(row * 4 + off);
                    store(a, 2'(s), $urandom());
                    load(a, 2'(s), 1'b0);
                    load(a, 2'(s), 1'b1);
                    read_neighbor_words(row);
                end
            end
        end

        // Extension with the top accessed bit at 0 and at 1
        for (int s = 0; s < 3; s++)
        begin
            top_mask = 32'h1 << (8 * s + 7);
            for (int top = 0; top < 2; top++)
            begin
                for (int sg = 0; sg < 2; sg++)
                begin
                    a = rand_addr(s + 1);
                    d = $urandom();
                    d = (top == 1) ? (d | top_mask) : (d & ~top_mask);
                    store(a, 2'(s), d);
                    load(a, 2'(s), 1'(sg));
                end
            end
        end

        // Same-cycle read returns old bytes and the next read the new ones
        for (int i = 0; i < 8; i++)
        begin
            sz = int'($urandom_range(3));
            a  = rand_addr(sz + 1);
            drive_cycle(1'b1, 1'b1, a, 2'(sz), 1'(i), $urandom());
            drive_cycle(1'b0, 1'b1, a, 2'(sz), 1'(i), '0);
            go_idle();
            wait_for_valid();
        end

        go_idle();
        repeat (2) @(posedge clk);

        if (reads_checked == 0)
        begin
            $display("No read results reached the response checks");
        end
        $display("Errors: rd_valid %0d, rd_data %0d, timeouts %0d, reads checked %0d",
                 valid_errors, data_errors, timeout_errors, reads_checked);
        if (valid_errors + data_errors + timeout_errors == 0 && reads_checked > 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/dmem_pkg.sv
hw/lane_steer.sv
hw/byte_lane_ram.sv
hw/load_align.sv
hw/dmem_top.sv
test/dmem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the data memory testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module dmem_tb -f sources.f -o dmem_sim \
    && ./obj_dir/dmem_sim | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null \
    && { echo "run_sim: simulation passed"; exit 0; } \
    || { echo "run_sim: simulation failed"; exit 1; }
